// File: compile.f
rgmii_pkg.sv
eth_pkg.sv
gmii_byte_if.sv
frame_check_if.sv
rgmii_rx.sv
eth_rx_decode.sv
eth_rx_check.sv
eth_rx_status.sv
eth_rx_top.sv
tb_clk_gen.sv
tb_eth_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build tb_eth_rx with verilator, run it, look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_eth_rx -f compile.f \
    -o tb_eth_rx_sim > build.log 2>&1 \
    && ./obj_dir/tb_eth_rx_sim > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; exit 1; }
grep -qx "Simulation passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

// File: tb_eth_rx.sv
`timescale 1ns/1ps

module tb_eth_rx
    import rgmii_pkg::*;
    import eth_pkg::*;
();

    localparam int        COUNT_W   = 16;
    localparam mac_addr_t LOCAL_MAC = 48'h02_1A_2B_3C_4D_5E;
    localparam mac_addr_t OTHER_MAC = 48'h02_1A_2B_3C_4D_5F;   // one bit off ours
    localparam mac_addr_t BCAST_MAC = 48'hFFFF_FFFF_FFFF;
    localparam mac_addr_t SRC_MAC   = 48'h02_AA_BB_CC_DD_EE;

    // payload lengths, frame bytes = payload + 12 addr + 4 fcs
    localparam int LEN_BIG   = 100;
    localparam int LEN_SHORT = 50;
    localparam int LEN_RUNT  = 24;    // 40 bytes on the count
    localparam int LEN_ERR   = 80;
    localparam int LEN_DROP  = 60;
    localparam int DROP_WINDOW = 40;  // quiet cycles expected after a dropped frame

    // nine frames, each with 8 preamble/sfd + 16 overhead
    localparam int TOTAL_BYTES = 2 * LEN_BIG + 2 * LEN_SHORT + 2 * LEN_RUNT + LEN_ERR
                               + 2 * LEN_DROP + 9 * 24;
    localparam int WATCHDOG_CYCLES = 2 * TOTAL_BYTES + DROP_WINDOW + 500;

    logic                gmii_rx_clk;
    logic                rst_n;
    nibble_t             rgmii_rxd;
    logic                rgmii_rx_ctl;
    logic                frame_done;
    frame_status_t       frame_status;
    frame_len_t          frame_len;
    logic [COUNT_W-1:0]  good_cnt;
    logic [COUNT_W-1:0]  err_cnt;
    logic [COUNT_W-1:0]  filt_cnt;

    gmii_byte_t frame_q[$];         // frame on the wire, preamble first
    logic [31:0] lcg_state = 32'd8;
    int n_errors = 0;
    int n_checks = 0;
    int exp_good = 0;               // own tallies from expected status
    int exp_err  = 0;
    int exp_filt = 0;

    tb_clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) u_clk_gen (
        .gmii_rx_clk (gmii_rx_clk),
        .rst_n       (rst_n)
    );

    eth_rx_top #(.LOCAL_MAC(LOCAL_MAC), .COUNT_W(COUNT_W)) dut0 (
        .gmii_rx_clk    (gmii_rx_clk),
        .rst_n          (rst_n),
        .rgmii_rxd      (rgmii_rxd),
        .rgmii_rx_ctl   (rgmii_rx_ctl),
        .frame_done     (frame_done),
        .frame_status   (frame_status),
        .frame_len      (frame_len),
        .good_count     (good_cnt),
        .error_count    (err_cnt),
        .filtered_count (filt_cnt)
    );

    // ********************************************************
    // frame building
    // ********************************************************

    function automatic gmii_byte_t rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];    // upper bits, low ones cycle fast
    endfunction

    // ieee crc-32 over dest..payload, lsb of each byte first
    function automatic crc_t fcs_calc();
        crc_t crc;
        crc = 32'hFFFF_FFFF;
        for (int i = 8; i < frame_q.size(); i++)
        begin
            for (int b = 0; b < 8; b++)
            begin
                if (crc[0] ^ frame_q[i][b])
                    crc = (crc >> 1) ^ 32'hEDB8_8320;
                else
                    crc = crc >> 1;
            end
        end
        return ~crc;
    endfunction

    task automatic build_frame(input mac_addr_t dst, input int payload_len);
        crc_t fcs;
        frame_q.delete();
        repeat (7) frame_q.push_back(ETH_PREAMBLE_BYTE);
        frame_q.push_back(ETH_SFD_BYTE);
        for (int i = 5; i >= 0; i--)
            frame_q.push_back(dst[i*8 +: 8]);       // first byte is [47:40]
        for (int i = 5; i >= 0; i--)
            frame_q.push_back(SRC_MAC[i*8 +: 8]);
        repeat (payload_len) frame_q.push_back(rand_byte());
        fcs = fcs_calc();
        for (int i = 0; i < 4; i++)
            frame_q.push_back(fcs[i*8 +: 8]);       // fcs goes out low byte first
    endtask

    // ********************************************************
    // rgmii driving
    // ********************************************************

    // low half is set up on the falling edge; the high half has to change
    // right after the rising edge, since ddr samples it on the next falling one
    task automatic send_byte(input gmii_byte_t b, input logic er);
        @(negedge gmii_rx_clk);
        rgmii_rxd    <= b[3:0];
        rgmii_rx_ctl <= 1'b1;          // rx_dv half
        @(posedge gmii_rx_clk);
        rgmii_rxd    <= b[7:4];
        rgmii_rx_ctl <= 1'b1 ^ er;     // dv xor er
    endtask

    task automatic send_frame(input int er_from, input int er_to);
        for (int i = 0; i < frame_q.size(); i++)
            send_byte(frame_q[i], (i >= er_from) && (i <= er_to));
        @(negedge gmii_rx_clk);
        rgmii_rxd    <= '0;            // idle, carrier off
        rgmii_rx_ctl <= 1'b0;
    endtask

    task automatic wait_done();
        do
            @(negedge gmii_rx_clk);    // outputs settled mid-cycle
        while (frame_done !== 1'b1);
    endtask

    // ********************************************************
    // compare tasks
    // ********************************************************

    task automatic check_status(input frame_status_t got, input frame_status_t exp,
                                input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Mismatch at %0t: %s status %s, expected %s", $time, what,
                     got.name(), exp.name());
        end
    endtask

    task automatic check_len(input frame_len_t got, input frame_len_t exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Mismatch at %0t: %s length %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input logic [COUNT_W-1:0] got, input logic [COUNT_W-1:0] exp,
                               input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ********************************************************
    // directed tests
    // ********************************************************

    task automatic run_frame(input frame_status_t exp, input int er_from, input int er_to,
                             input string what);
        send_frame(er_from, er_to);
        wait_done();
        check_status(frame_status, exp, what);
        check_len(frame_len, frame_len_t'(frame_q.size() - 8), what);
        case (exp)
            FRAME_GOOD:     exp_good++;
            FRAME_FILTERED: exp_filt++;
            default:        exp_err++;
        endcase
    endtask

    task automatic test_reset_and_unicast();
        check_flag(frame_done, 1'b0, "frame_done after reset");
        check_count(good_cnt, '0, "good_count after reset");
        check_count(err_cnt, '0, "error_count after reset");
        check_count(filt_cnt, '0, "filtered_count after reset");
        build_frame(LOCAL_MAC, LEN_BIG);
        run_frame(FRAME_GOOD, -1, -1, "unicast");
    endtask

    task automatic test_bcast_and_filter();
        build_frame(BCAST_MAC, LEN_SHORT);
        run_frame(FRAME_GOOD, -1, -1, "broadcast");
        build_frame(OTHER_MAC, LEN_SHORT);
        run_frame(FRAME_FILTERED, -1, -1, "foreign unicast");
    endtask

    task automatic test_crc_bad();
        build_frame(LOCAL_MAC, LEN_BIG);
        frame_q[8 + 12 + 5] ^= 8'h10;     // payload hit after fcs
        run_frame(FRAME_CRC_BAD, -1, -1, "flipped payload");
    endtask

    task automatic test_runt();
        build_frame(LOCAL_MAC, LEN_RUNT);
        run_frame(FRAME_RUNT, -1, -1, "runt");
        build_frame(LOCAL_MAC, LEN_RUNT);
        frame_q[8 + 14] ^= 8'h01;         // also bad crc, runt still wins
        run_frame(FRAME_RUNT, -1, -1, "runt with bad fcs");
    endtask

    task automatic test_phy_err_and_drop();
        build_frame(LOCAL_MAC, LEN_ERR);
        run_frame(FRAME_PHY_ERR, 30, 31, "rx_er in body");
        build_frame(LOCAL_MAC, LEN_DROP);
        frame_q[1] = 8'h5A;               // broken second preamble byte
        send_frame(-1, -1);
        repeat (DROP_WINDOW)
        begin
            @(negedge gmii_rx_clk);
            if (frame_done === 1'b1)
            begin
                n_errors++;
                $display("Error at %0t: a frame with a bad preamble was reported", $time);
            end
        end
        build_frame(LOCAL_MAC, LEN_DROP);
        run_frame(FRAME_GOOD, -1, -1, "good frame after drop");
    endtask

    task automatic test_counters();
        check_count(good_cnt, exp_good[COUNT_W-1:0], "good_count");
        check_count(err_cnt, exp_err[COUNT_W-1:0], "error_count");
        check_count(filt_cnt, exp_filt[COUNT_W-1:0], "filtered_count");
    endtask

    // ********************************************************
    // run control
    // ********************************************************

    initial
    begin
        rgmii_rxd    = '0;
        rgmii_rx_ctl = 1'b0;
        @(posedge rst_n);
        @(negedge gmii_rx_clk);
        test_reset_and_unicast();
        test_bcast_and_filter();
        test_crc_bad();
        test_runt();
        test_phy_err_and_drop();
        test_counters();
        $display("Done: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge gmii_rx_clk);
        $display("Timeout: frame_done did not arrive within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

// free-running rx clock and power-on reset
module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
)
(
    output logic gmii_rx_clk,
    output logic rst_n
);

    initial
    begin
        gmii_rx_clk = 1'b0;
        forever #(PERIOD_NS / 2) gmii_rx_clk = ~gmii_rx_clk;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge gmii_rx_clk);
        @(negedge gmii_rx_clk);
        rst_n <= 1'b1;   // released away from the rising edge
    end

endmodule

// File: eth_rx_top.sv
`timescale 1ns/1ps

module eth_rx_top
    import rgmii_pkg::*;
    import eth_pkg::*;
#(
    parameter mac_addr_t LOCAL_MAC = 48'h02_00_00_00_00_01,   // our station address
    parameter int        COUNT_W   = 16                       // statistics width
)
(
    input  logic               gmii_rx_clk,   // phy rxc
    input  logic               rst_n,
    input  nibble_t            rgmii_rxd,
    input  logic               rgmii_rx_ctl,
    output logic               frame_done,
    output frame_status_t      frame_status,
    output frame_len_t         frame_len,
    output logic [COUNT_W-1:0] good_count,
    output logic [COUNT_W-1:0] error_count,
    output logic [COUNT_W-1:0] filtered_count
);

    // gmii between capture and decoder
    gmii_byte_t gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;

    gmii_byte_if   rx_bytes ();   // decoder -> checker
    frame_check_if rx_check ();   // checker -> status

    // ********************************************************
    // decode
    // ********************************************************

    rgmii_rx u_rgmii_rx (
        .gmii_rx_clk  (gmii_rx_clk),
        .rst_n        (rst_n),
        .rgmii_rxd    (rgmii_rxd),
        .rgmii_rx_ctl (rgmii_rx_ctl),
        .gmii_rxd     (gmii_rxd),
        .gmii_rx_dv   (gmii_rx_dv),
        .gmii_rx_er   (gmii_rx_er)
    );

    eth_rx_decode u_eth_rx_decode (
        .gmii_rx_clk (gmii_rx_clk),
        .rst_n       (rst_n),
        .gmii_rxd    (gmii_rxd),
        .gmii_rx_dv  (gmii_rx_dv),
        .gmii_rx_er  (gmii_rx_er),
        .byte_out    (rx_bytes.src)
    );

    // ********************************************************
    // execute and result
    // ********************************************************

    eth_rx_check #(
        .LOCAL_MAC (LOCAL_MAC)
    ) u_eth_rx_check (
        .gmii_rx_clk (gmii_rx_clk),
        .rst_n       (rst_n),
        .byte_in     (rx_bytes.snk),
        .result      (rx_check.src)
    );

    eth_rx_status #(
        .COUNT_W (COUNT_W)
    ) u_eth_rx_status (
        .gmii_rx_clk    (gmii_rx_clk),
        .rst_n          (rst_n),
        .result         (rx_check.snk),
        .frame_done     (frame_done),
        .frame_status   (frame_status),
        .frame_len      (frame_len),
        .good_count     (good_count),
        .error_count    (error_count),
        .filtered_count (filtered_count)
    );

endmodule

// File: eth_rx_status.sv
`timescale 1ns/1ps

module eth_rx_status
    import eth_pkg::*;
#(
    parameter int COUNT_W = 16
)
(
    input  logic               gmii_rx_clk,
    input  logic               rst_n,
    frame_check_if.snk         result,
    output logic               frame_done,
    output frame_status_t      frame_status,
    output frame_len_t         frame_len,
    output logic [COUNT_W-1:0] good_count,
    output logic [COUNT_W-1:0] error_count,
    output logic [COUNT_W-1:0] filtered_count
);

    frame_status_t status_c;

    // counters stick at all ones
    function automatic logic [COUNT_W-1:0] sat_inc(input logic [COUNT_W-1:0] v);
        return (v == '1) ? v : v + 1'b1;
    endfunction

    // ********************************************************
    // classification, first match wins
    // ********************************************************

    always_comb
    begin
        if (result.phy_err)
            status_c = FRAME_PHY_ERR;
        else if (result.len < MIN_FRAME_LEN)
            status_c = FRAME_RUNT;        // ahead of crc
        else if (!result.crc_ok)
            status_c = FRAME_CRC_BAD;
        else if (!result.addr_ok)
            status_c = FRAME_FILTERED;
        else
            status_c = FRAME_GOOD;
    end

    always_ff @(posedge gmii_rx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_done     <= 1'b0;
            good_count     <= '0;
            error_count    <= '0;
            filtered_count <= '0;
        end
        else
        begin
            frame_done <= result.done;
            if (result.done)
            begin
                case (status_c)
                    FRAME_GOOD:     good_count     <= sat_inc(good_count);
                    FRAME_FILTERED: filtered_count <= sat_inc(filtered_count);
                    default:        error_count    <= sat_inc(error_count);   // phy, runt, crc
                endcase
            end
        end
    end

    always_ff @(posedge gmii_rx_clk)
    begin
        if (result.done)
        begin
            frame_status <= status_c;
            frame_len    <= result.len;
        end
    end

endmodule

// File: eth_rx_check.sv
`timescale 1ns/1ps

module eth_rx_check
    import rgmii_pkg::*;
    import eth_pkg::*;
#(
    parameter mac_addr_t LOCAL_MAC = 48'h02_00_00_00_00_01
)
(
    input  logic       gmii_rx_clk,
    input  logic       rst_n,
    gmii_byte_if.snk   byte_in,
    frame_check_if.src result
);

    localparam crc_t      CRC_POLY  = 32'hEDB8_8320;   // 0x04C11DB7 reflected
    localparam crc_t      CRC_SEED  = 32'hFFFF_FFFF;
    localparam mac_addr_t BCAST_MAC = '1;

    crc_t       crc_q;
    crc_t       crc_next;
    frame_len_t len_q;      // bytes taken so far
    frame_len_t len_next;
    frame_len_t idx;        // position of the byte on the bus
    mac_addr_t  dst_q;      // dest addr, shifted in msb first
    mac_addr_t  dst_next;

    // one byte through the crc, lsb first as on the wire
    function automatic crc_t crc_byte(input crc_t crc, input gmii_byte_t data);
        crc_t c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++)
        begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    // reflected register -> msb-first form of the residue
    function automatic crc_t bit_rev(input crc_t v);
        crc_t r;
        for (int i = 0; i < 32; i++)
        begin
            r[i] = v[31 - i];
        end
        return r;
    endfunction

    // ********************************************************
    // next-byte values
    // ********************************************************

    always_comb
    begin
        idx      = byte_in.sof ? '0 : len_q;
        len_next = (idx == '1) ? idx : idx + 16'd1;   // pinned at max
        crc_next = crc_byte(byte_in.sof ? CRC_SEED : crc_q, byte_in.data);
        dst_next = dst_q;
        if (idx < 16'd6)
        begin
            dst_next = {dst_q[39:0], byte_in.data};   // bytes 0..5
        end
    end

    // ********************************************************
    // per-frame state and result
    // ********************************************************

    always_ff @(posedge gmii_rx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            len_q       <= '0;
            result.done <= 1'b0;
        end
        else
        begin
            result.done <= byte_in.valid & byte_in.eof;   // clock after the eof byte
            if (byte_in.valid)
            begin
                len_q <= len_next;
            end
        end
    end

    always_ff @(posedge gmii_rx_clk)
    begin
        if (byte_in.valid)
        begin
            crc_q <= crc_next;
            dst_q <= dst_next;
        end
        if (byte_in.valid && byte_in.eof)
        begin
            result.len     <= len_next;
            result.crc_ok  <= (bit_rev(crc_next) == CRC_RESIDUE);   // fcs included
            result.addr_ok <= (dst_next == LOCAL_MAC) || (dst_next == BCAST_MAC);
            result.phy_err <= byte_in.err;
        end
    end

endmodule

// File: eth_rx_decode.sv
`timescale 1ns/1ps

module eth_rx_decode
    import rgmii_pkg::*;
    import eth_pkg::*;
(
    input  logic       gmii_rx_clk,
    input  logic       rst_n,
    input  gmii_byte_t gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    gmii_byte_if.src   byte_out
);

    decode_state_t state_q;
    gmii_byte_t    hold_q;       // one byte look-ahead for eof
    logic          hold_vld_q;   // hold_q has a body byte
    logic          hold_sof_q;   // ... and it is the first one
    logic          first_q;      // next body byte is the first
    logic          err_q;        // sticky rx_er over the body

    // ********************************************************
    // preamble / sfd state machine and byte stream
    // ********************************************************

    always_ff @(posedge gmii_rx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q        <= IDLE;
            hold_vld_q     <= 1'b0;
            hold_sof_q     <= 1'b0;
            first_q        <= 1'b0;
            err_q          <= 1'b0;
            byte_out.valid <= 1'b0;
            byte_out.sof   <= 1'b0;
            byte_out.eof   <= 1'b0;
            byte_out.err   <= 1'b0;
        end
        else
        begin
            byte_out.valid <= 1'b0;   // quiet unless BODY says otherwise
            byte_out.sof   <= 1'b0;
            byte_out.eof   <= 1'b0;
            byte_out.err   <= 1'b0;
            case (state_q)
                IDLE:
                begin
                    if (gmii_rx_dv)
                    begin
                        // carrier must open with a preamble byte
                        state_q <= (gmii_rxd == ETH_PREAMBLE_BYTE) ? PREAMBLE : DROP;
                    end
                end
                PREAMBLE:
                begin
                    if (!gmii_rx_dv)
                    begin
                        state_q <= IDLE;             // carrier gone before sfd
                    end
                    else if (gmii_rxd == ETH_SFD_BYTE)
                    begin
                        state_q    <= BODY;
                        first_q    <= 1'b1;
                        hold_vld_q <= 1'b0;
                        err_q      <= 1'b0;          // fresh frame
                    end
                    else if (gmii_rxd != ETH_PREAMBLE_BYTE)
                    begin
                        state_q <= DROP;
                    end
                end
                BODY:
                begin
                    // held byte goes out one clock after it was taken
                    byte_out.valid <= hold_vld_q;
                    byte_out.sof   <= hold_vld_q & hold_sof_q;
                    if (gmii_rx_dv)
                    begin
                        hold_vld_q <= 1'b1;
                        hold_sof_q <= first_q;
                        first_q    <= 1'b0;
                        err_q      <= err_q | gmii_rx_er;
                    end
                    else
                    begin
                        // dv fell, the byte in hold was the last
                        byte_out.eof <= hold_vld_q;
                        byte_out.err <= hold_vld_q & err_q;
                        hold_vld_q   <= 1'b0;
                        state_q      <= IDLE;
                    end
                end
                DROP:
                begin
                    if (!gmii_rx_dv)
                    begin
                        state_q <= IDLE;
                    end
                end
                default:
                begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // data path
    always_ff @(posedge gmii_rx_clk)
    begin
        if ((state_q == BODY) && gmii_rx_dv)
        begin
            hold_q <= gmii_rxd;
        end
        byte_out.data <= hold_q;   // lines up with valid above
    end

endmodule

// File: rgmii_rx.sv
`timescale 1ns/1ps

module rgmii_rx
    import rgmii_pkg::*;
(
    input  logic       gmii_rx_clk,    // phy rxc, used directly
    input  logic       rst_n,
    input  nibble_t    rgmii_rxd,
    input  logic       rgmii_rx_ctl,
    output gmii_byte_t gmii_rxd,
    output logic       gmii_rx_dv,
    output logic       gmii_rx_er
);

    nibble_t lo_nib_q;     // bits 3:0, rising edge
    nibble_t hi_nib_q;     // bits 7:4, falling edge
    logic    ctl_rise_q;   // rx_dv half of ctl
    logic    ctl_fall_q;   // rx_dv ^ rx_er half of ctl

    // ********************************************************
    // ddr capture
    // ********************************************************

    always_ff @(posedge gmii_rx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ctl_rise_q <= 1'b0;
        end
        else
        begin
            ctl_rise_q <= rgmii_rx_ctl;
        end
    end

    always_ff @(negedge gmii_rx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ctl_fall_q <= 1'b0;
        end
        else
        begin
            ctl_fall_q <= rgmii_rx_ctl;
        end
    end

    always_ff @(posedge gmii_rx_clk)
    begin
        lo_nib_q <= rgmii_rxd;
    end

    always_ff @(negedge gmii_rx_clk)
    begin
        hi_nib_q <= rgmii_rxd;   // second half of the same byte
    end

    // ********************************************************
    // byte assembly, next rising edge
    // ********************************************************

    always_ff @(posedge gmii_rx_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gmii_rx_dv <= 1'b0;
            gmii_rx_er <= 1'b0;
        end
        else
        begin
            gmii_rx_dv <= ctl_rise_q;
            gmii_rx_er <= ctl_rise_q ^ ctl_fall_q;   // rgmii codes er as xor
        end
    end

    always_ff @(posedge gmii_rx_clk)
    begin
        gmii_rxd <= {hi_nib_q, lo_nib_q};
    end

endmodule

// File: frame_check_if.sv
`timescale 1ns/1ps

// per-frame check results, checker -> result stage
interface frame_check_if
    import eth_pkg::*;
();

    logic       done;      // single clock pulse per finished frame
    frame_len_t len;       // bytes from dest addr through fcs
    logic       crc_ok;    // register hit the residue
    logic       addr_ok;   // unicast to us or broadcast
    logic       phy_err;   // rx_er seen in the body

    // fields are only meaningful with done
    modport src (
        output done, len, crc_ok, addr_ok, phy_err
    );

    modport snk (
        input  done, len, crc_ok, addr_ok, phy_err
    );

endinterface

// File: gmii_byte_if.sv
`timescale 1ns/1ps

// decoded frame bytes, decoder -> checker
// no handshake, the line can't be paused
interface gmii_byte_if
    import rgmii_pkg::*;
();

    gmii_byte_t data;    // frame byte, dest addr first
    logic       valid;   // one byte per clock while high
    logic       sof;     // first byte after the sfd
    logic       eof;     // last byte (end of fcs)
    logic       err;     // with eof, phy flagged rx_er somewhere in the frame

    modport src (
        output data, valid, sof, eof, err
    );

    modport snk (
        input  data, valid, sof, eof, err
    );

endinterface

// File: eth_pkg.sv
package eth_pkg;

    import rgmii_pkg::*;

    // ********************************************************
    // frame level types
    // ********************************************************

    typedef logic [47:0] mac_addr_t;   // first byte on the wire sits in [47:40]
    typedef logic [31:0] crc_t;
    typedef logic [15:0] frame_len_t;  // dest addr through fcs

    localparam gmii_byte_t ETH_PREAMBLE_BYTE = 8'h55;
    localparam gmii_byte_t ETH_SFD_BYTE      = 8'hD5;

    // remainder left by a clean frame with its fcs, msb-first form
    localparam crc_t CRC_RESIDUE = 32'hC704_DD7B;

    localparam frame_len_t MIN_FRAME_LEN = 16'd64;  // incl fcs

    // ********************************************************
    // state machine and result encodings
    // ********************************************************

    typedef enum logic [1:0] {
        IDLE,       // line quiet
        PREAMBLE,   // 0x55 run, waiting for sfd
        BODY,       // frame bytes going out
        DROP        // bad preamble, sit out the carrier
    } decode_state_t;

    typedef enum logic [2:0] {
        FRAME_GOOD,
        FRAME_PHY_ERR,
        FRAME_RUNT,
        FRAME_CRC_BAD,
        FRAME_FILTERED
    } frame_status_t;

endpackage

// File: rgmii_pkg.sv
package rgmii_pkg;

    // ********************************************************
    // pin-level types, phy side and gmii side
    // ********************************************************

    // one ddr half of the rgmii data bus
    // rising edge carries bits 3:0, falling edge bits 7:4
    typedef logic [3:0] nibble_t;

    // gmii receive byte, one per rx clock at 1000 Mb/s
    typedef logic [7:0] gmii_byte_t;

endpackage
